// ==== hdl/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Data and address width of the fetch path.
`define FETCH_XLEN 32

// Words fetched ahead of the next PC.
`define FETCH_PREFETCH_NUM 2

// Pending FIFO depth. Also bounds reads in flight.
`define FETCH_PENDING_DEPTH 2

// Returned words kept for extraction.
`define FETCH_BUFFER_DEPTH 2

// First PC after reset.
`define FETCH_RESET_ADDR 32'h0000_0000

// Machine-mode return, SYSTEM opcode with funct12 0x302.
`define FETCH_MRET_OPCODE 32'h3020_0073

`endif

// ==== hdl/fetch_pkg.sv ====
`default_nettype none
`include "fetch_settings.svh"

package fetch_pkg;

  // Word address, byte address shifted right by two.
  typedef logic [`FETCH_XLEN-3:0] word_addr_t;

  typedef struct packed {
    logic       valid;  // Slot holds a live word address.
    word_addr_t addr;
  } word_tag_t;

  // One bus word, seen whole or as two halfwords.
  typedef union packed {
    logic [`FETCH_XLEN-1:0]           full;
    logic [1:0][`FETCH_XLEN/2-1:0]    half;  // half[0] is the lower address.
  } fetch_word_u;

  typedef struct packed {
    word_tag_t   tag;
    fetch_word_u data;
  } buf_entry_t;

  typedef struct packed {
    logic                   read;     // Read strobe.
    logic [`FETCH_XLEN-1:0] address;  // Byte address, always word aligned.
  } bus_req_t;

  typedef struct packed {
    logic                   request_ready;    // Read accepted this cycle when strobed.
    logic                   read_data_valid;  // One returned word.
    logic [`FETCH_XLEN-1:0] read_data;
  } bus_rsp_t;

  typedef struct packed {
    logic [`FETCH_XLEN-1:0] istr;
    logic [`FETCH_XLEN-1:0] pc;
  } fetch_out_t;

  typedef struct packed {
    logic                   jump_en;       // Execute-stage jump.
    logic [`FETCH_XLEN-1:0] jump_addr;
    logic                   bp_jump_en;    // Branch predictor taken.
    logic [`FETCH_XLEN-1:0] bp_jump_addr;
    logic [`FETCH_XLEN-1:0] mepc;          // Saved exception PC for mret.
  } redirect_t;

  typedef struct packed {
    logic cur_word;   // Word holding the PC is absent.
    logic next_word;  // Word after it is absent.
  } miss_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_pending_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

// Tags of reads the bus has accepted but not yet answered.
module fetch_pending_fifo
  import fetch_pkg::*;
#(
  parameter int DEPTH = `FETCH_PENDING_DEPTH
) (
  input  wire             clk,
  input  wire             rest,
  input  wire             push,
  input  wire word_tag_t  push_tag,
  input  wire             pop,
  output word_tag_t       head,
  output logic            empty,
  output logic            full,
  output word_tag_t       all_tags [DEPTH]
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PW-1:0] LAST = PW'(DEPTH - 1);

  word_addr_t       slot_addr [DEPTH];  // Payload only.
  logic [DEPTH-1:0] occ;                // One bit per occupied slot.
  logic [PW-1:0]    wr_ptr;
  logic [PW-1:0]    rd_ptr;
  logic             wr_en;
  logic             rd_en;

  assign wr_en = push && push_tag.valid && !occ[wr_ptr];  // Never overwrite a live slot.
  assign rd_en = pop && occ[rd_ptr];

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      occ    <= '0;
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (rd_en) begin
        occ[rd_ptr] <= 1'b0;
        rd_ptr      <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      // Set after clear, so a same-slot push wins.
      if (wr_en) begin
        occ[wr_ptr] <= 1'b1;
        wr_ptr      <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      slot_addr[wr_ptr] <= push_tag.addr;
    end
  end

  assign empty = ~|occ;
  assign full  = &occ;
  assign head  = '{valid: occ[rd_ptr], addr: slot_addr[rd_ptr]};

  // Every slot visible, idle ones with valid low.
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      all_tags[i] = '{valid: occ[i], addr: slot_addr[i]};
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_word_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

// Last few returned words, newest in slot 0.
module fetch_word_buffer
  import fetch_pkg::*;
#(
  parameter int DEPTH = `FETCH_BUFFER_DEPTH
) (
  input  wire              clk,
  input  wire              rest,
  input  wire              write,
  input  wire buf_entry_t  entry,
  output buf_entry_t       all_entries [DEPTH]
);

  logic [DEPTH-1:0] vld;            // Tag valid bits, the only reset state.
  buf_entry_t       store [DEPTH];  // Word and tag payload.

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      vld <= '0;
    end else if (write) begin
      vld[0] <= entry.tag.valid;
      for (int i = 1; i < DEPTH; i++) begin
        vld[i] <= vld[i-1];  // Oldest falls off the end.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (write) begin
      store[0] <= entry;
      for (int i = 1; i < DEPTH; i++) begin
        store[i] <= store[i-1];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      all_entries[i]           = store[i];
      all_entries[i].tag.valid = vld[i];  // Reset-safe valid.
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_prefetch_addr.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

// Picks the next word to read and drives the read strobe.
module fetch_prefetch_addr
  import fetch_pkg::*;
#(
  parameter int PF_NUM     = `FETCH_PREFETCH_NUM,
  parameter int PEND_DEPTH = `FETCH_PENDING_DEPTH,
  parameter int BUF_DEPTH  = `FETCH_BUFFER_DEPTH
) (
  input  wire logic [`FETCH_XLEN-1:0] pc,
  input  wire logic [`FETCH_XLEN-1:0] next_pc,
  input  wire miss_t                  miss,
  input  wire word_tag_t              pending [PEND_DEPTH],
  input  wire                         pending_full,
  input  wire word_tag_t              buffered [BUF_DEPTH],
  output bus_req_t                    bus_req
);

  word_addr_t        pf_word [PF_NUM];  // Words at and after next_pc.
  logic [PF_NUM-1:0] pf_seen;           // Already buffered or in flight.
  word_addr_t        pf_pick;
  logic              pf_need;
  word_addr_t        pc_word;
  word_addr_t        rd_word;

  assign pc_word = pc[`FETCH_XLEN-1:2];

  always_comb begin
    for (int i = 0; i < PF_NUM; i++) begin
      pf_word[i] = next_pc[`FETCH_XLEN-1:2] + word_addr_t'(i);
      pf_seen[i] = 1'b0;
      for (int j = 0; j < PEND_DEPTH; j++) begin
        pf_seen[i] |= pending[j].valid && (pending[j].addr == pf_word[i]);
      end
      for (int j = 0; j < BUF_DEPTH; j++) begin
        pf_seen[i] |= buffered[j].valid && (buffered[j].addr == pf_word[i]);
      end
    end
  end

  // Lowest unseen prefetch word.
  always_comb begin
    pf_need = 1'b0;
    pf_pick = pf_word[0];
    for (int i = PF_NUM - 1; i >= 0; i--) begin
      if (!pf_seen[i]) begin
        pf_need = 1'b1;
        pf_pick = pf_word[i];
      end
    end
  end

  // Misses on the current instruction beat plain prefetch.
  always_comb begin
    if (miss.cur_word) begin
      rd_word = pc_word;
    end else if (miss.next_word) begin
      rd_word = pc_word + 1'b1;  // Upper half of a straddling instruction.
    end else begin
      rd_word = pf_pick;
    end
  end

  // Full FIFO caps the reads in flight.
  assign bus_req.read    = !pending_full && (miss.cur_word || miss.next_word || pf_need);
  assign bus_req.address = {rd_word, 2'b00};

endmodule

`default_nettype wire

// ==== hdl/fetch_istr_extract.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

// Builds the instruction at pc from buffered halfwords.
module fetch_istr_extract
  import fetch_pkg::*;
#(
  parameter int BUF_DEPTH  = `FETCH_BUFFER_DEPTH,
  parameter int PEND_DEPTH = `FETCH_PENDING_DEPTH
) (
  input  wire logic [`FETCH_XLEN-1:0] pc,
  input  wire buf_entry_t             entries [BUF_DEPTH+1],  // Last slot is the bypass.
  input  wire word_tag_t              pending [PEND_DEPTH],
  output fetch_word_u                 istr,
  output logic                        istr_valid,
  output logic                        istr_is_mret,
  output miss_t                       miss
);

  localparam int NUM_ENT = BUF_DEPTH + 1;

  word_addr_t               word_lo;   // Word holding pc.
  word_addr_t               word_hi;   // Word after it.
  logic [NUM_ENT-1:0]       hit_lo;
  logic [NUM_ENT-1:0]       hit_hi;
  logic                     pend_lo;
  logic                     pend_hi;
  logic                     have_lo;
  logic                     have_hi;
  fetch_word_u              data_lo;
  fetch_word_u              data_hi;
  logic [`FETCH_XLEN/2-1:0] half_first;
  logic [`FETCH_XLEN/2-1:0] half_second;
  logic                     is_32;

  assign word_lo = pc[`FETCH_XLEN-1:2];
  assign word_hi = word_lo + 1'b1;

  always_comb begin
    pend_lo = 1'b0;
    pend_hi = 1'b0;
    for (int j = 0; j < NUM_ENT; j++) begin
      hit_lo[j] = entries[j].tag.valid && (entries[j].tag.addr == word_lo);
      hit_hi[j] = entries[j].tag.valid && (entries[j].tag.addr == word_hi);
    end
    for (int j = 0; j < PEND_DEPTH; j++) begin
      pend_lo |= pending[j].valid && (pending[j].addr == word_lo);
      pend_hi |= pending[j].valid && (pending[j].addr == word_hi);
    end
  end

  // First matching entry supplies the data.
  always_comb begin
    data_lo = '0;
    data_hi = '0;
    for (int j = NUM_ENT - 1; j >= 0; j--) begin
      if (hit_lo[j]) begin
        data_lo = entries[j].data;
      end
      if (hit_hi[j]) begin
        data_hi = entries[j].data;
      end
    end
  end

  assign have_lo = |hit_lo;
  assign have_hi = |hit_hi;

  // Halfword pick. pc[1] set means the instruction starts mid-word.
  assign half_first  = pc[1] ? data_lo.half[1] : data_lo.half[0];
  assign half_second = pc[1] ? data_hi.half[0] : data_lo.half[1];
  assign is_32       = (half_first[1:0] == 2'b11);  // RVC uses 00, 01, 10.

  always_comb begin
    istr.half[0] = half_first;
    istr.half[1] = is_32 ? half_second : '0;  // Compressed keeps a clean upper half.
  end

  // Straddling needs the next word too.
  assign istr_valid   = have_lo && (!is_32 || !pc[1] || have_hi);
  assign istr_is_mret = istr_valid && (istr.full == `FETCH_MRET_OPCODE);

  // Only words nobody is fetching yet.
  assign miss.cur_word  = !have_lo && !pend_lo;
  assign miss.next_word = have_lo && is_32 && pc[1] && !have_hi && !pend_hi;

endmodule

`default_nettype wire

// ==== hdl/fetch_pc_seq.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

// PC register, next-PC select and the delivery stage.
module fetch_pc_seq
  import fetch_pkg::*;
(
  input  wire                         clk,
  input  wire                         rest,
  input  wire redirect_t              redirect,
  input  wire                         flush,
  input  wire fetch_word_u            istr,
  input  wire                         istr_valid,
  input  wire                         istr_is_mret,
  input  wire                         dely_ready,
  output logic [`FETCH_XLEN-1:0]      pc,
  output logic [`FETCH_XLEN-1:0]      next_pc,
  output fetch_out_t                  dely,
  output logic                        dely_valid
);

  logic                   pc_valid;  // Low for the first cycle after reset.
  logic                   out_free;  // Delivery register can load.
  logic                   take;      // Current instruction moves to delivery.
  logic                   pc_en;
  logic [`FETCH_XLEN-1:0] pc_step;

  assign out_free = !dely_valid || dely_ready;
  assign take     = istr_valid && out_free;
  assign pc_step  = (istr.full[1:0] == 2'b11) ? `FETCH_XLEN'(4) : `FETCH_XLEN'(2);
  assign pc_en    = !pc_valid || redirect.jump_en || take;

  // Jump first, then predictor or mret, then sequential.
  always_comb begin
    if (redirect.jump_en) begin
      next_pc = redirect.jump_addr;
    end else if (take && redirect.bp_jump_en) begin
      next_pc = redirect.bp_jump_addr;  // Branch itself still delivered.
    end else if (take && istr_is_mret) begin
      next_pc = redirect.mepc;
    end else if (take) begin
      next_pc = pc + pc_step;
    end else begin
      next_pc = pc;  // Stalled or waiting on the bus.
    end
  end

  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      pc_valid <= 1'b0;
      pc       <= `FETCH_RESET_ADDR;
    end else begin
      pc_valid <= 1'b1;
      if (pc_en) begin
        pc <= next_pc;
      end
    end
  end

  // Hold while the consumer stalls. Flush kills the incoming one.
  always_ff @(posedge clk or negedge rest) begin
    if (!rest) begin
      dely_valid <= 1'b0;
    end else if (out_free) begin
      dely_valid <= istr_valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      dely.istr <= istr.full;
      dely.pc   <= pc;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

// Fetch stage top.
module fetch_unit
  import fetch_pkg::*;
(
  input  wire                         clk,
  input  wire                         rest,
  input  wire bus_rsp_t               bus_rsp,
  output bus_req_t                    bus_req,
  input  wire redirect_t              redirect,
  input  wire                         flush,
  output logic [`FETCH_XLEN-1:0]      bp_istr,
  output logic [`FETCH_XLEN-1:0]      bp_pc,
  output fetch_out_t                  dely,
  output logic                        dely_valid,
  input  wire                         dely_ready
);

  localparam int PEND = `FETCH_PENDING_DEPTH;
  localparam int BUFD = `FETCH_BUFFER_DEPTH;

  logic [`FETCH_XLEN-1:0] pc;
  logic [`FETCH_XLEN-1:0] next_pc;
  fetch_word_u            istr;
  logic                   istr_valid;
  logic                   istr_is_mret;
  miss_t                  miss;
  word_tag_t              pend_tags [PEND];
  word_tag_t              pend_head;
  word_tag_t              push_tag;
  logic                   pend_push;
  logic                   pend_pop;
  logic                   pend_empty;
  logic                   pend_full;
  buf_entry_t             buf_entries [BUFD];
  buf_entry_t             new_entry;    // Word returning this cycle.
  buf_entry_t             ext_entries [BUFD+1];
  word_tag_t              buf_tags [BUFD];
  logic                   buf_write;

  assign pend_push = bus_req.read && bus_rsp.request_ready;  // Accepted read.
  assign push_tag  = '{valid: 1'b1, addr: bus_req.address[`FETCH_XLEN-1:2]};
  assign pend_pop  = bus_rsp.read_data_valid;                // In-order return.
  assign buf_write = bus_rsp.read_data_valid && !pend_empty;

  assign new_entry.tag  = '{valid: buf_write, addr: pend_head.addr};
  assign new_entry.data = bus_rsp.read_data;

  // Buffer plus bypass for the extractor, tags only for the prefetcher.
  always_comb begin
    for (int i = 0; i < BUFD; i++) begin
      ext_entries[i] = buf_entries[i];
      buf_tags[i]    = buf_entries[i].tag;
    end
    ext_entries[BUFD] = new_entry;
  end

  assign bp_istr = istr.full;
  assign bp_pc   = pc;

  fetch_pc_seq i_fetch_pc_seq (
    .clk          (clk),
    .rest         (rest),
    .redirect     (redirect),
    .flush        (flush),
    .istr         (istr),
    .istr_valid   (istr_valid),
    .istr_is_mret (istr_is_mret),
    .dely_ready   (dely_ready),
    .pc           (pc),
    .next_pc      (next_pc),
    .dely         (dely),
    .dely_valid   (dely_valid)
  );

  fetch_prefetch_addr #(
    .PF_NUM     (`FETCH_PREFETCH_NUM),
    .PEND_DEPTH (PEND),
    .BUF_DEPTH  (BUFD)
  ) i_fetch_prefetch_addr (
    .pc           (pc),
    .next_pc      (next_pc),
    .miss         (miss),
    .pending      (pend_tags),
    .pending_full (pend_full),
    .buffered     (buf_tags),
    .bus_req      (bus_req)
  );

  fetch_pending_fifo #(
    .DEPTH (PEND)
  ) i_fetch_pending_fifo (
    .clk      (clk),
    .rest     (rest),
    .push     (pend_push),
    .push_tag (push_tag),
    .pop      (pend_pop),
    .head     (pend_head),
    .empty    (pend_empty),
    .full     (pend_full),
    .all_tags (pend_tags)
  );

  fetch_word_buffer #(
    .DEPTH (BUFD)
  ) i_fetch_word_buffer (
    .clk         (clk),
    .rest        (rest),
    .write       (buf_write),
    .entry       (new_entry),
    .all_entries (buf_entries)
  );

  fetch_istr_extract #(
    .BUF_DEPTH  (BUFD),
    .PEND_DEPTH (PEND)
  ) i_fetch_istr_extract (
    .pc           (pc),
    .entries      (ext_entries),
    .pending      (pend_tags),
    .istr         (istr),
    .istr_valid   (istr_valid),
    .istr_is_mret (istr_is_mret),
    .miss         (miss)
  );

endmodule

`default_nettype wire

// ==== verif/tb_fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "fetch_settings.svh"

module tb_fetch_unit
  import fetch_pkg::*;
();

  localparam int MEM_WORDS = 64;  // 256 byte memory image.
  localparam int PEND      = `FETCH_PENDING_DEPTH;

  logic       clk;
  logic       rest;
  bus_req_t   bus_req;
  bus_rsp_t   bus_rsp;
  redirect_t  redirect;
  logic       flush;
  logic [31:0] bp_istr;
  logic [31:0] bp_pc;
  fetch_out_t dely;
  logic       dely_valid;
  logic       dely_ready;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] lfsr = 32'hecf4_1827;
  logic [31:0] mepc;
  fetch_out_t  exp_q [$];     // Expected delivered stream.
  logic [31:0] bp_from [$];   // Predicted branch PCs.
  logic [31:0] bp_to [$];
  int          jump_at [$];   // Delivery count that triggers the jump.
  logic [31:0] jump_to [$];
  logic [31:0] rd_addr_q [$]; // Reads in flight, in order.
  longint      rd_due_q [$];
  longint      cycle;
  longint      last_due;
  logic [31:0] ret_addr;
  logic        ret_now;       // A word returns this cycle.
  fetch_out_t  offer;         // Instruction and PC shown to the predictor.
  logic        offer_live;    // Offer went into the output register at the last edge.
  logic        loaded;
  int          n_dely;
  int          jump_idx;
  int          dely_errs;
  int          bus_errs;

  fetch_unit i_fetch_unit (
    .clk        (clk),
    .rest       (rest),
    .bus_rsp    (bus_rsp),
    .bus_req    (bus_req),
    .redirect   (redirect),
    .flush      (flush),
    .bp_istr    (bp_istr),
    .bp_pc      (bp_pc),
    .dely       (dely),
    .dely_valid (dely_valid),
    .dely_ready (dely_ready)
  );

  always #50 clk = ~clk;

  // Galois LFSR, one step per bit.
  function automatic logic rand_bit();
    logic b;
    b    = lfsr[0];
    lfsr = lfsr >> 1;
    if (b) lfsr = lfsr ^ 32'h8020_0003;
    return b;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) v = (v << 1) | int'(rand_bit());
    return v;
  endfunction

  task automatic check_fetch_out(input fetch_out_t got, input fetch_out_t exp, input int idx,
                                 input string what);
    if (got !== exp) begin
      dely_errs++;
      $display("[FAIL] %0t ns: %s %0d got pc %h istr %h, expected pc %h istr %h",
               $time, what, idx + 1, got.pc, got.istr, exp.pc, exp.istr);
    end
  endtask

  task automatic check_bus_req(input bus_req_t got);
    if (got.address[1:0] !== 2'b00 || got.address >= 32'(MEM_WORDS * 4)) begin
      bus_errs++;
      $display("[FAIL] %0t ns: read address %h unaligned or outside the image",
               $time, got.address);
    end
  endtask

  task automatic load_stimulus(output logic ok);
    int          fd;
    int          code;
    int          k;
    logic [7:0]  kind;
    logic [31:0] a;
    logic [31:0] d;
    fetch_out_t  e;
    logic [8*200-1:0] line;
    ok = 1'b0;
    for (int i = 0; i < MEM_WORDS; i++) mem[i] = 32'h13 | (i << 7);  // ADDI fill per word.
    fd = $fopen("verif/fetch_stimulus.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd)) begin
      code = $fscanf(fd, " %c", kind);
      if (code != 1) break;
      case (kind)
        "#": code = $fgets(line, fd);  // Comment line.
        "m": begin
          code = $fscanf(fd, " %h %h", a, d);
          mem[a] = d;
        end
        "e": code = $fscanf(fd, " %h", mepc);
        "b": begin
          code = $fscanf(fd, " %h %h", a, d);
          bp_from.push_back(a);
          bp_to.push_back(d);
        end
        "j": begin
          code = $fscanf(fd, " %d %h", k, d);
          jump_at.push_back(k);
          jump_to.push_back(d);
        end
        "x": begin
          code = $fscanf(fd, " %h %h", a, d);
          e.istr = d;
          e.pc   = a;
          exp_q.push_back(e);
        end
        default: ;
      endcase
    end
    $fclose(fd);
    ok = 1'b1;
  endtask

  // Inputs for one cycle, applied just after the rising edge.
  task automatic drive_inputs();
    bus_rsp = '0;
    ret_now = 1'b0;
    bus_rsp.request_ready = (rand_bits(2) != 0);
    if (rd_addr_q.size() > 0 && rd_due_q[0] <= cycle) begin
      ret_now  = 1'b1;
      ret_addr = rd_addr_q.pop_front();
      void'(rd_due_q.pop_front());
      bus_rsp.read_data_valid = 1'b1;
      bus_rsp.read_data       = mem[int'(ret_addr >> 2)];
    end
    redirect      = '0;
    redirect.mepc = mepc;
    flush         = 1'b0;
    for (int i = 0; i < bp_from.size(); i++) begin
      if (bp_pc == bp_from[i]) begin
        redirect.bp_jump_en   = 1'b1;  // Predictor answers in the same cycle.
        redirect.bp_jump_addr = bp_to[i];
      end
    end
    dely_ready = (rand_bits(2) != 0);
    if (jump_idx < jump_at.size() && dely_valid && n_dely == jump_at[jump_idx] - 1) begin
      dely_ready         = 1'b1;  // Delivery k leaves in this cycle.
      redirect.jump_en   = 1'b1;
      redirect.jump_addr = jump_to[jump_idx];
      flush              = 1'b1;
      jump_idx++;
    end
  endtask

  // Mid-cycle sample of the transfers at the next edge.
  task automatic sample_outputs();
    longint due;
    int     inflight;
    logic   dup;
    // Output just loaded, so the predictor saw the next expected one.
    if (offer_live && dely_valid) begin
      check_fetch_out(offer, exp_q[n_dely], n_dely, "predictor view of delivery");
    end
    if (dely_valid && dely_ready) begin
      check_fetch_out(dely, exp_q[n_dely], n_dely, "delivery");
      n_dely++;
    end
    if (bus_req.read && bus_rsp.request_ready) begin
      check_bus_req(bus_req);
      inflight = rd_addr_q.size() + int'(ret_now);
      if (inflight >= PEND) begin
        bus_errs++;
        $display("Error at %0t ns: read accepted with %0d reads already in flight",
                 $time, inflight);
      end
      dup = ret_now && (ret_addr == bus_req.address);  // Returning word is still pending.
      foreach (rd_addr_q[i]) begin
        if (rd_addr_q[i] == bus_req.address) dup = 1'b1;
      end
      if (dup) begin
        bus_errs++;
        $display("Error at %0t ns: word %h requested again while pending",
                 $time, bus_req.address);
      end
      due = cycle + 1 + rand_bits(2);  // Latency 1 to 4 cycles.
      if (due <= last_due) due = last_due + 1;
      last_due = due;
      rd_addr_q.push_back(bus_req.address);
      rd_due_q.push_back(due);
    end
    offer.istr = bp_istr;
    offer.pc   = bp_pc;
    offer_live = (!dely_valid || dely_ready) && !flush;  // Output register can load.
  endtask

  initial begin
    logic ok;
    clk        = 1'b0;
    rest       = 1'b0;
    bus_rsp    = '0;
    redirect   = '0;
    flush      = 1'b0;
    dely_ready = 1'b0;
    mepc       = '0;
    loaded     = 1'b0;
    n_dely     = 0;
    jump_idx   = 0;
    dely_errs  = 0;
    bus_errs   = 0;
    cycle      = 0;
    last_due   = 0;
    ret_now    = 1'b0;
    ret_addr   = '0;
    offer      = '0;
    offer_live = 1'b0;
    load_stimulus(ok);
    if (!ok) begin
      $display("Could not open the stimulus file verif/fetch_stimulus.txt");
      $display("*** TEST FAILED ***");
    end else begin
      loaded = 1'b1;
      redirect.mepc = mepc;
      repeat (10) @(posedge clk);
      #5 rest = 1'b1;
      while (n_dely < exp_q.size()) begin
        @(posedge clk);
        #5;
        cycle++;
        drive_inputs();
        @(negedge clk);
        sample_outputs();
      end
      $display("Errors: delivery %0d, bus %0d; %0d deliveries checked",
               dely_errs, bus_errs, n_dely);
      if (dely_errs == 0 && bus_errs == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
    end
    $finish;
  end

  // Watchdog sized by the expected stream.
  initial begin
    int limit;
    wait (loaded);
    limit = 200 * exp_q.size() + 1000 + 10;
    repeat (limit) @(posedge clk);
    $display("Watchdog expired after %0d cycles with %0d of %0d deliveries seen",
             limit, n_dely, exp_q.size());
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/fetch_pending_fifo.sv
hdl/fetch_word_buffer.sv
hdl/fetch_prefetch_addr.sv
hdl/fetch_istr_extract.sv
hdl/fetch_pc_seq.sv
hdl/fetch_unit.sv
verif/tb_fetch_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch unit testbench with Verilator, from the project root.
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_fetch_unit -f verilog.f \
  -o tb_fetch_unit || exit 1
out=$(./obj_dir/tb_fetch_unit)
echo "$out"
echo "$out" | grep -qF '*** TEST PASSED ***' && exit 0 || exit 1

// ==== verif/fetch_stimulus.txt ====
# m <word index> <data>, e <mepc>, b <branch pc> <target>, x <pc> <instruction>: hex.
# j <delivery count, decimal> <target pc, hex>: jump and flush in the cycle of that delivery.
m 00 00100093
m 01 01134085
m 02 00010020
m 03 81934109
m 04 02130030
m 05 00010040
m 10 00734185
m 11 00013020
m 20 00500293
m 21 42890001
m 22 00600313
m 23 00700393
m 24 00800413
m 30 04930001
m 31 45050090
m 32 00a00513
m 33 00010001
e 80
b 12 40
j 13 c2
x 00 00100093
x 04 00004085
x 06 00200113
x 0a 00000001
x 0c 00004109
x 0e 00308193
x 12 00400213
x 40 00004185
x 42 30200073
x 80 00500293
x 84 00000001
x 86 00004289
x 88 00600313
x c2 00900493
x c6 00004505
x c8 00a00513
x cc 00000001
x ce 00000001
